//--- common/lite_bus_pkg.sv
// lite bus types

package lite_bus_pkg;

   ////////////////////////////////////////
   // widths

   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [DATA_W/8-1:0] strb_t;  // one bit per data byte

   ////////////////////////////////////////
   // response codes

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10,
      DECERR = 2'b11   // no slot matched
   } resp_e;

endpackage

//--- common/io_map_pkg.sv
// io device slot map

package io_map_pkg;

   import lite_bus_pkg::*;

   localparam int N_SLOTS = 3;

   typedef enum int unsigned {
      SLOT_HOST = 0,  // test host
      SLOT_UART = 1,
      SLOT_SPI  = 2
   } slot_e;

   typedef logic [N_SLOTS-1:0] slot_sel_t;  // one-hot

   // index 0 is the host slot, listed high slot first
   localparam addr_t [N_SLOTS-1:0] SLOT_BASE = {
      32'h4000_2000,   // spi
      32'h4000_1000,   // uart
      32'h4000_0000    // host
   };

   localparam addr_t [N_SLOTS-1:0] SLOT_MASK = {
      32'h0000_0FFF,
      32'h0000_0FFF,
      32'h0000_0FFF
   };

endpackage

//--- common/lite_if.sv
// lite bus channel bundle
`timescale 1ns/1ns

interface lite_if
   import lite_bus_pkg::*;
();

   // write address, data, response
   logic  aw_valid, aw_ready;
   addr_t aw_addr;
   logic  w_valid, w_ready;
   data_t w_data;
   strb_t w_strb;
   logic  b_valid, b_ready;
   resp_e b_resp;

   // read address and data
   logic  ar_valid, ar_ready;
   addr_t ar_addr;
   logic  r_valid, r_ready;
   data_t r_data;
   resp_e r_resp;

   modport initiator (
      output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
      output ar_valid, ar_addr, r_ready,
      input  aw_ready, w_ready, b_valid, b_resp,
      input  ar_ready, r_valid, r_data, r_resp
   );

   modport target (
      input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
      input  ar_valid, ar_addr, r_ready,
      output aw_ready, w_ready, b_valid, b_resp,
      output ar_ready, r_valid, r_data, r_resp
   );

endinterface

//--- io_crossbar/io_addr_decode.sv
// io slot address decoder
`timescale 1ns/1ns

module io_addr_decode
   import lite_bus_pkg::*;
   import io_map_pkg::*;
#(
   parameter int ADDR_W = lite_bus_pkg::ADDR_W,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_BASE = io_map_pkg::SLOT_BASE,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_MASK = io_map_pkg::SLOT_MASK
) (
   input  addr_t     addr_i,
   output slot_sel_t sel_o,
   output logic      hit_o
);

   // mask bits are the offset inside a slot
   always_comb begin
      for (int i = 0; i < N_SLOTS; i++) begin
         sel_o[i] = (addr_i & ~SLOT_MASK[i]) == (SLOT_BASE[i] & ~SLOT_MASK[i]);
      end
   end

   assign hit_o = |sel_o;

   // overlapping slot ranges would select two devices at once
   always_comb begin
      assert ($onehot0(sel_o))
         else $error("io_addr_decode: address %h hits several slots", addr_i);
   end

endmodule

//--- io_crossbar/io_write_router.sv
// lite write channel router
`timescale 1ns/1ns

module io_write_router
   import lite_bus_pkg::*;
   import io_map_pkg::*;
#(
   parameter int ADDR_W = lite_bus_pkg::ADDR_W,
   parameter int DATA_W = lite_bus_pkg::DATA_W,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_BASE = io_map_pkg::SLOT_BASE,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_MASK = io_map_pkg::SLOT_MASK
) (
   input  logic      clk_i,
   input  logic      arst_n_i,
   lite_if.target    up,
   lite_if.initiator dev [N_SLOTS]
);

   typedef enum logic [1:0] {W_IDLE, W_FWD, W_WAIT, W_RESP} wr_state_e;

   wr_state_e           state_q;
   slot_sel_t           sel_q, dec_sel;
   logic                dec_hit, accept;
   logic                aw_done_q, w_done_q;
   logic                aw_hs, w_hs, b_hs;
   logic [ADDR_W-1:0]   addr_q;
   logic [DATA_W-1:0]   data_q;
   logic [DATA_W/8-1:0] strb_q;
   resp_e               resp_q, b_resp_sel;
   slot_sel_t           aw_valid_v, aw_ready_v, w_valid_v, w_ready_v, b_valid_v;
   resp_e               b_resp_v [N_SLOTS];

   io_addr_decode #(
      .ADDR_W    (ADDR_W),
      .SLOT_BASE (SLOT_BASE),
      .SLOT_MASK (SLOT_MASK)
   ) u_decode (
      .addr_i (up.aw_addr),
      .sel_o  (dec_sel),
      .hit_o  (dec_hit)
   );

   ////////////////////////////////////////
   // upstream side

   assign up.aw_ready = (state_q == W_IDLE);
   assign up.w_ready  = (state_q == W_IDLE);
   assign up.b_valid  = (state_q == W_RESP);
   assign up.b_resp   = resp_q;
   assign accept      = (state_q == W_IDLE) && up.aw_valid && up.w_valid;

   ////////////////////////////////////////
   // device side

   assign aw_valid_v = (state_q == W_FWD && !aw_done_q) ? sel_q : '0;
   assign w_valid_v  = (state_q == W_FWD && !w_done_q) ? sel_q : '0;
   assign aw_hs      = |(aw_valid_v & aw_ready_v);
   assign w_hs       = |(w_valid_v & w_ready_v);
   assign b_hs       = (state_q == W_WAIT) && |(sel_q & b_valid_v);

   for (genvar i = 0; i < N_SLOTS; i++) begin : g_dev
      assign dev[i].aw_valid = aw_valid_v[i];
      assign dev[i].aw_addr  = addr_q;
      assign dev[i].w_valid  = w_valid_v[i];
      assign dev[i].w_data   = data_q;
      assign dev[i].w_strb   = strb_q;
      assign dev[i].b_ready  = (state_q == W_WAIT) && sel_q[i];
      assign aw_ready_v[i]   = dev[i].aw_ready;
      assign w_ready_v[i]    = dev[i].w_ready;
      assign b_valid_v[i]    = dev[i].b_valid;
      assign b_resp_v[i]     = dev[i].b_resp;

      a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         aw_valid_v[i] && !aw_ready_v[i] |=> aw_valid_v[i])
         else $error("io_write_router: aw valid dropped before ready");
   end

   always_comb begin
      b_resp_sel = OKAY;
      for (int i = 0; i < N_SLOTS; i++) begin
         if (sel_q[i]) b_resp_sel = b_resp_v[i];
      end
   end

   // one write in flight, aw and w complete in any order
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= W_IDLE;
         sel_q     <= '0;
         aw_done_q <= 1'b0;
         w_done_q  <= 1'b0;
      end else begin
         case (state_q)
            W_IDLE: if (accept) begin
               sel_q     <= dec_sel;
               aw_done_q <= 1'b0;
               w_done_q  <= 1'b0;
               state_q   <= dec_hit ? W_FWD : W_RESP;
            end
            W_FWD: begin
               if (aw_hs) aw_done_q <= 1'b1;
               if (w_hs) w_done_q <= 1'b1;
               if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) state_q <= W_WAIT;
            end
            W_WAIT: if (b_hs) state_q <= W_RESP;
            W_RESP: if (up.b_ready) state_q <= W_IDLE;
            default: state_q <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q <= up.aw_addr;
         data_q <= up.w_data;
         strb_q <= up.w_strb;
      end
      if (accept && !dec_hit) resp_q <= DECERR;  // never forwarded
      else if (b_hs) resp_q <= b_resp_sel;
   end

   a_aw_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(aw_valid_v))
      else $error("io_write_router: several device aw valids");

endmodule

//--- io_crossbar/io_read_router.sv
// lite read channel router
`timescale 1ns/1ns

module io_read_router
   import lite_bus_pkg::*;
   import io_map_pkg::*;
#(
   parameter int ADDR_W = lite_bus_pkg::ADDR_W,
   parameter int DATA_W = lite_bus_pkg::DATA_W,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_BASE = io_map_pkg::SLOT_BASE,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_MASK = io_map_pkg::SLOT_MASK
) (
   input  logic      clk_i,
   input  logic      arst_n_i,
   lite_if.target    up,
   lite_if.initiator dev [N_SLOTS]
);

   typedef enum logic [1:0] {R_IDLE, R_FWD, R_WAIT, R_RESP} rd_state_e;

   rd_state_e         state_q;
   slot_sel_t         sel_q, dec_sel;
   logic              dec_hit, accept, ar_hs, r_hs;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] data_q, r_data_sel;
   resp_e             resp_q, r_resp_sel;
   slot_sel_t         ar_ready_v, r_valid_v;
   data_t             r_data_v [N_SLOTS];
   resp_e             r_resp_v [N_SLOTS];

   io_addr_decode #(
      .ADDR_W    (ADDR_W),
      .SLOT_BASE (SLOT_BASE),
      .SLOT_MASK (SLOT_MASK)
   ) u_decode (
      .addr_i (up.ar_addr),
      .sel_o  (dec_sel),
      .hit_o  (dec_hit)
   );

   assign up.ar_ready = (state_q == R_IDLE);
   assign up.r_valid  = (state_q == R_RESP);
   assign up.r_data   = data_q;
   assign up.r_resp   = resp_q;
   assign accept      = (state_q == R_IDLE) && up.ar_valid;
   assign ar_hs       = (state_q == R_FWD) && |(sel_q & ar_ready_v);
   assign r_hs        = (state_q == R_WAIT) && |(sel_q & r_valid_v);

   for (genvar i = 0; i < N_SLOTS; i++) begin : g_dev
      assign dev[i].ar_valid = (state_q == R_FWD) && sel_q[i];
      assign dev[i].ar_addr  = addr_q;
      assign dev[i].r_ready  = (state_q == R_WAIT) && sel_q[i];
      assign ar_ready_v[i]   = dev[i].ar_ready;
      assign r_valid_v[i]    = dev[i].r_valid;
      assign r_data_v[i]     = dev[i].r_data;
      assign r_resp_v[i]     = dev[i].r_resp;
   end

   always_comb begin
      r_data_sel = '0;
      r_resp_sel = OKAY;
      for (int i = 0; i < N_SLOTS; i++) begin
         if (sel_q[i]) begin
            r_data_sel = r_data_v[i];
            r_resp_sel = r_resp_v[i];
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= R_IDLE;
         sel_q   <= '0;
      end else begin
         case (state_q)
            R_IDLE: if (accept) begin
               sel_q   <= dec_sel;
               state_q <= dec_hit ? R_FWD : R_RESP;
            end
            R_FWD:  if (ar_hs) state_q <= R_WAIT;
            R_WAIT: if (r_hs) state_q <= R_RESP;
            R_RESP: if (up.r_ready) state_q <= R_IDLE;
            default: state_q <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) addr_q <= up.ar_addr;
      if (accept && !dec_hit) begin
         data_q <= '0;      // decode error carries no data
         resp_q <= DECERR;
      end else if (r_hs) begin
         data_q <= r_data_sel;
         resp_q <= r_resp_sel;
      end
   end

   a_r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      up.r_valid && !up.r_ready |=> up.r_valid && $stable(up.r_data))
      else $error("io_read_router: upstream r dropped or changed before ready");

endmodule

//--- src/io_subsys_top.sv
// io crossbar top level
`timescale 1ns/1ns

module io_subsys_top
   import lite_bus_pkg::*;
   import io_map_pkg::*;
#(
   parameter int ADDR_W = lite_bus_pkg::ADDR_W,
   parameter int DATA_W = lite_bus_pkg::DATA_W,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_BASE = io_map_pkg::SLOT_BASE,
   parameter logic [N_SLOTS-1:0][ADDR_W-1:0] SLOT_MASK = io_map_pkg::SLOT_MASK
) (
   input  logic                               clk_i,
   input  logic                               arst_n_i,
   // upstream from the processor
   input  logic                               s_aw_valid_i,
   output logic                               s_aw_ready_o,
   input  logic [ADDR_W-1:0]                  s_aw_addr_i,
   input  logic                               s_w_valid_i,
   output logic                               s_w_ready_o,
   input  logic [DATA_W-1:0]                  s_w_data_i,
   input  logic [DATA_W/8-1:0]                s_w_strb_i,
   output logic                               s_b_valid_o,
   input  logic                               s_b_ready_i,
   output logic [1:0]                         s_b_resp_o,
   input  logic                               s_ar_valid_i,
   output logic                               s_ar_ready_o,
   input  logic [ADDR_W-1:0]                  s_ar_addr_i,
   output logic                               s_r_valid_o,
   input  logic                               s_r_ready_i,
   output logic [DATA_W-1:0]                  s_r_data_o,
   output logic [1:0]                         s_r_resp_o,
   // device slots, host / uart / spi
   output logic [N_SLOTS-1:0]                 m_aw_valid_o,
   input  logic [N_SLOTS-1:0]                 m_aw_ready_i,
   output logic [N_SLOTS-1:0][ADDR_W-1:0]     m_aw_addr_o,
   output logic [N_SLOTS-1:0]                 m_w_valid_o,
   input  logic [N_SLOTS-1:0]                 m_w_ready_i,
   output logic [N_SLOTS-1:0][DATA_W-1:0]     m_w_data_o,
   output logic [N_SLOTS-1:0][DATA_W/8-1:0]   m_w_strb_o,
   input  logic [N_SLOTS-1:0]                 m_b_valid_i,
   output logic [N_SLOTS-1:0]                 m_b_ready_o,
   input  logic [N_SLOTS-1:0][1:0]            m_b_resp_i,
   output logic [N_SLOTS-1:0]                 m_ar_valid_o,
   input  logic [N_SLOTS-1:0]                 m_ar_ready_i,
   output logic [N_SLOTS-1:0][ADDR_W-1:0]     m_ar_addr_o,
   input  logic [N_SLOTS-1:0]                 m_r_valid_i,
   output logic [N_SLOTS-1:0]                 m_r_ready_o,
   input  logic [N_SLOTS-1:0][DATA_W-1:0]     m_r_data_i,
   input  logic [N_SLOTS-1:0][1:0]            m_r_resp_i
);

   lite_if up ();
   lite_if dev [N_SLOTS] ();

   ////////////////////////////////////////
   // upstream bundle

   assign up.aw_valid  = s_aw_valid_i;
   assign up.aw_addr   = s_aw_addr_i;
   assign s_aw_ready_o = up.aw_ready;
   assign up.w_valid   = s_w_valid_i;
   assign up.w_data    = s_w_data_i;
   assign up.w_strb    = s_w_strb_i;
   assign s_w_ready_o  = up.w_ready;
   assign s_b_valid_o  = up.b_valid;
   assign s_b_resp_o   = up.b_resp;
   assign up.b_ready   = s_b_ready_i;
   assign up.ar_valid  = s_ar_valid_i;
   assign up.ar_addr   = s_ar_addr_i;
   assign s_ar_ready_o = up.ar_ready;
   assign s_r_valid_o  = up.r_valid;
   assign s_r_data_o   = up.r_data;
   assign s_r_resp_o   = up.r_resp;
   assign up.r_ready   = s_r_ready_i;

   ////////////////////////////////////////
   // device bundles

   for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
      assign m_aw_valid_o[i] = dev[i].aw_valid;
      assign m_aw_addr_o[i]  = dev[i].aw_addr;
      assign dev[i].aw_ready = m_aw_ready_i[i];
      assign m_w_valid_o[i]  = dev[i].w_valid;
      assign m_w_data_o[i]   = dev[i].w_data;
      assign m_w_strb_o[i]   = dev[i].w_strb;
      assign dev[i].w_ready  = m_w_ready_i[i];
      assign dev[i].b_valid  = m_b_valid_i[i];
      assign dev[i].b_resp   = resp_e'(m_b_resp_i[i]);
      assign m_b_ready_o[i]  = dev[i].b_ready;
      assign m_ar_valid_o[i] = dev[i].ar_valid;
      assign m_ar_addr_o[i]  = dev[i].ar_addr;
      assign dev[i].ar_ready = m_ar_ready_i[i];
      assign dev[i].r_valid  = m_r_valid_i[i];
      assign dev[i].r_data   = m_r_data_i[i];
      assign dev[i].r_resp   = resp_e'(m_r_resp_i[i]);
      assign m_r_ready_o[i]  = dev[i].r_ready;
   end

   // write and read paths run independently
   io_write_router #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .SLOT_BASE (SLOT_BASE),
      .SLOT_MASK (SLOT_MASK)
   ) u_write_router (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .up       (up),
      .dev      (dev)
   );

   io_read_router #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .SLOT_BASE (SLOT_BASE),
      .SLOT_MASK (SLOT_MASK)
   ) u_read_router (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .up       (up),
      .dev      (dev)
   );

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 3
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD/2) clk_o = ~clk_o;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 arst_n_o = 1'b1;  // released just after an edge
   end

endmodule

//--- verif/tb_io_subsys.sv
// io crossbar testbench
`timescale 1ns/1ns

module tb_io_subsys;

   localparam int          N_DEV     = 3;
   localparam int          TIMEOUT   = 50;  // cycles per wait
   localparam logic [31:0] OFFS_MASK = 32'h0000_0FFF;
   localparam logic [31:0] DEV_BASE [N_DEV] = '{32'h4000_0000, 32'h4000_1000, 32'h4000_2000};
   localparam logic [31:0] LFSR_SEED = 32'h591593ef;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;
   localparam string       CASE_FILE = "verif/io_cases.txt";

   logic clk, arst_n;
   logic s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
   logic s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
   logic [31:0] s_aw_addr, s_ar_addr;
   logic [63:0] s_w_data, s_r_data;
   logic [7:0]  s_w_strb;
   logic [1:0]  s_b_resp, s_r_resp;
   logic [N_DEV-1:0] m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
   logic [N_DEV-1:0] m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
   logic [N_DEV-1:0][31:0] m_aw_addr, m_ar_addr;
   logic [N_DEV-1:0][63:0] m_w_data, m_r_data;
   logic [N_DEV-1:0][7:0]  m_w_strb;
   logic [N_DEV-1:0][1:0]  m_b_resp, m_r_resp;

   logic [N_DEV-1:0][31:0] wr_count, rd_count, last_wr, last_rd;  // device records
   logic [31:0] lfsr_q;
   logic        rand_en, aborted;
   int          test_err, pass_count, fail_count, round;
   string       cur_name;

   tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clk (.clk_o(clk), .arst_n_o(arst_n));

   io_subsys_top UUT (
      .clk_i (clk), .arst_n_i (arst_n),
      .s_aw_valid_i (s_aw_valid), .s_aw_ready_o (s_aw_ready), .s_aw_addr_i (s_aw_addr),
      .s_w_valid_i (s_w_valid), .s_w_ready_o (s_w_ready),
      .s_w_data_i (s_w_data), .s_w_strb_i (s_w_strb),
      .s_b_valid_o (s_b_valid), .s_b_ready_i (s_b_ready), .s_b_resp_o (s_b_resp),
      .s_ar_valid_i (s_ar_valid), .s_ar_ready_o (s_ar_ready), .s_ar_addr_i (s_ar_addr),
      .s_r_valid_o (s_r_valid), .s_r_ready_i (s_r_ready),
      .s_r_data_o (s_r_data), .s_r_resp_o (s_r_resp),
      .m_aw_valid_o (m_aw_valid), .m_aw_ready_i (m_aw_ready), .m_aw_addr_o (m_aw_addr),
      .m_w_valid_o (m_w_valid), .m_w_ready_i (m_w_ready),
      .m_w_data_o (m_w_data), .m_w_strb_o (m_w_strb),
      .m_b_valid_i (m_b_valid), .m_b_ready_o (m_b_ready), .m_b_resp_i (m_b_resp),
      .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready), .m_ar_addr_o (m_ar_addr),
      .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready),
      .m_r_data_i (m_r_data), .m_r_resp_i (m_r_resp)
   );

   ////////////////////////////////////////
   // helpers

   // galois lfsr stepped once per bit
   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int k = 0; k < n; k++) begin
         v = (v << 1) | int'(lfsr_q[0]);
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      end
      return v;
   endfunction

   function automatic int slot_of(input logic [31:0] addr);
      int s;
      s = N_DEV;  // no slot
      for (int i = 0; i < N_DEV; i++) begin
         if ((addr & ~OFFS_MASK) == DEV_BASE[i]) s = i;
      end
      return s;
   endfunction

   task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] got);
      assert (got === exp)
         else begin
            $display("CHECK FAILED %0s %0s: expected %0h, actual %0h", cur_name, what, exp, got);
            test_err++;
         end
   endtask

   task automatic expect_held(input logic v, input string what);
      assert (v)
         else begin
            $display("%0s: %0s dropped before its handshake", cur_name, what);
            test_err++;
         end
   endtask

   task automatic report_timeout(input string what);
      $display("%0s: %0s within %0d cycles", cur_name, what, TIMEOUT);
      test_err++;
      aborted = 1'b1;
   endtask

   ////////////////////////////////////////
   // one device model per slot

   for (genvar s = 0; s < N_DEV; s++) begin : g_dev
      logic [63:0] mem [16];
      logic        aw_rdy, w_rdy, b_vld, ar_rdy, r_vld;
      logic [63:0] r_dat;
      logic [31:0] wr_addr, rd_addr;
      int          wr_seen, rd_seen;

      assign m_aw_ready[s] = aw_rdy;
      assign m_w_ready[s]  = w_rdy;
      assign m_b_valid[s]  = b_vld;
      assign m_b_resp[s]   = 2'b00;
      assign m_ar_ready[s] = ar_rdy;
      assign m_r_valid[s]  = r_vld;
      assign m_r_data[s]   = r_dat;
      assign m_r_resp[s]   = 2'b00;
      assign wr_count[s]   = wr_seen;
      assign rd_count[s]   = rd_seen;
      assign last_wr[s]    = wr_addr;
      assign last_rd[s]    = rd_addr;

      initial begin : write_side
         int          t;
         int          dly;
         logic [31:0] a;
         logic [63:0] d;
         logic [7:0]  st;
         aw_rdy = 1'b0;
         w_rdy = 1'b0;
         b_vld = 1'b0;
         wr_seen = 0;
         wr_addr = '0;
         forever begin
            @(negedge clk);
            if (m_aw_valid[s] && m_w_valid[s]) begin
               dly = rand_en ? rand_bits(2) : 0;
               repeat (dly) @(negedge clk);
               @(posedge clk);
               #1;
               aw_rdy = 1'b1;
               w_rdy = 1'b1;
               @(negedge clk);
               a = m_aw_addr[s];
               d = m_w_data[s];
               st = m_w_strb[s];
               @(posedge clk);
               #1;
               aw_rdy = 1'b0;
               w_rdy = 1'b0;
               for (int b = 0; b < 8; b++) begin
                  if (st[b]) mem[a[6:3]][8*b +: 8] = d[8*b +: 8];
               end
               wr_addr = a;
               wr_seen++;
               b_vld = 1'b1;
               t = 0;
               do begin
                  @(negedge clk);
                  t++;
               end while (!m_b_ready[s] && t < TIMEOUT);
               if (!m_b_ready[s]) report_timeout("device write response was not taken");
               @(posedge clk);
               #1 b_vld = 1'b0;
            end
         end
      end

      initial begin : read_side
         int          t;
         int          dly;
         logic [31:0] a;
         ar_rdy = 1'b0;
         r_vld = 1'b0;
         r_dat = '0;
         rd_seen = 0;
         rd_addr = '0;
         forever begin
            @(negedge clk);
            if (m_ar_valid[s]) begin
               dly = rand_en ? rand_bits(2) : 0;
               repeat (dly) @(negedge clk);
               @(posedge clk);
               #1 ar_rdy = 1'b1;
               @(negedge clk);
               a = m_ar_addr[s];
               @(posedge clk);
               #1 ar_rdy = 1'b0;
               rd_addr = a;
               rd_seen++;
               r_dat = mem[a[6:3]];
               r_vld = 1'b1;
               t = 0;
               do begin
                  @(negedge clk);
                  t++;
               end while (!m_r_ready[s] && t < TIMEOUT);
               if (!m_r_ready[s]) report_timeout("device read data was not taken");
               @(posedge clk);
               #1 r_vld = 1'b0;
            end
         end
      end
   end

   ////////////////////////////////////////
   // upstream transfers

   task automatic up_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, output logic [1:0] resp);
      int t;
      int dly;
      resp = 2'b00;
      @(posedge clk);
      #1;
      s_aw_valid = 1'b1;
      s_aw_addr = addr;
      s_w_valid = 1'b1;
      s_w_data = data;
      s_w_strb = strb;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!(s_aw_ready && s_w_ready) && t < TIMEOUT);
      if (!(s_aw_ready && s_w_ready)) begin
         report_timeout("write was not accepted");
         return;
      end
      @(posedge clk);
      #1;
      s_aw_valid = 1'b0;
      s_w_valid = 1'b0;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!s_b_valid && t < TIMEOUT);
      if (!s_b_valid) begin
         report_timeout("no write response came back");
         return;
      end
      dly = rand_en ? rand_bits(2) : 0;
      repeat (dly) begin
         @(negedge clk);
         expect_held(s_b_valid, "write response valid");
      end
      @(posedge clk);
      #1 s_b_ready = 1'b1;
      @(negedge clk);
      expect_held(s_b_valid, "write response valid");
      resp = s_b_resp;
      @(posedge clk);
      #1 s_b_ready = 1'b0;
   endtask

   task automatic up_read(input logic [31:0] addr, output logic [1:0] resp,
                          output logic [63:0] data);
      int t;
      int dly;
      resp = 2'b00;
      data = '0;
      @(posedge clk);
      #1;
      s_ar_valid = 1'b1;
      s_ar_addr = addr;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!s_ar_ready && t < TIMEOUT);
      if (!s_ar_ready) begin
         report_timeout("read address was not accepted");
         return;
      end
      @(posedge clk);
      #1 s_ar_valid = 1'b0;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!s_r_valid && t < TIMEOUT);
      if (!s_r_valid) begin
         report_timeout("no read data came back");
         return;
      end
      dly = rand_en ? rand_bits(2) : 0;
      repeat (dly) begin
         @(negedge clk);
         expect_held(s_r_valid, "read data valid");
      end
      @(posedge clk);
      #1 s_r_ready = 1'b1;
      @(negedge clk);
      expect_held(s_r_valid, "read data valid");
      resp = s_r_resp;
      data = s_r_data;
      @(posedge clk);
      #1 s_r_ready = 1'b0;
   endtask

   ////////////////////////////////////////
   // test sequencing

   task automatic finish_test();
      if (test_err == 0) begin
         pass_count++;
         $display("round %0d %0s ok", round, cur_name);
      end else begin
         fail_count++;
         $display("round %0d %0s failed", round, cur_name);
      end
   endtask

   task automatic run_case(input string op, input logic [31:0] addr, input logic [63:0] wdata,
                           input logic [7:0] strb, input logic [1:0] exp_resp,
                           input logic [63:0] exp_data);
      logic [N_DEV-1:0][31:0] wr_before, rd_before;
      logic [31:0]            wr_exp, rd_exp;
      logic [1:0]             resp;
      logic [63:0]            data;
      int                     slot;
      test_err = 0;
      slot = slot_of(addr);
      wr_before = wr_count;
      rd_before = rd_count;
      if (op == "write") begin
         up_write(addr, wdata, strb, resp);
      end else begin
         up_read(addr, resp, data);
         if (!aborted) check_eq("read data", exp_data, data);
      end
      if (!aborted) begin
         check_eq("response", 64'(exp_resp), 64'(resp));
         // only the decoded slot sees the transfer and sees it once
         for (int i = 0; i < N_DEV; i++) begin
            wr_exp = wr_before[i] + ((op == "write" && slot == i) ? 32'd1 : 32'd0);
            rd_exp = rd_before[i] + ((op != "write" && slot == i) ? 32'd1 : 32'd0);
            check_eq($sformatf("slot %0d writes", i), 64'(wr_exp), 64'(wr_count[i]));
            check_eq($sformatf("slot %0d reads", i), 64'(rd_exp), 64'(rd_count[i]));
         end
         if (slot < N_DEV) begin
            check_eq("device address", 64'(addr),
                     64'((op == "write") ? last_wr[slot] : last_rd[slot]));
         end
      end
      finish_test();
   endtask

   task automatic run_cases();
      int          fd;
      string       line, name, op;
      logic [31:0] addr;
      logic [63:0] wdata, rdata;
      logic [7:0]  strb;
      logic [1:0]  resp;
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         $display("cannot open %0s", CASE_FILE);
         aborted = 1'b1;
         return;
      end
      while (!$feof(fd) && !aborted) begin
         line = "";
         void'($fgets(line, fd));
         // comment and blank lines do not give all seven fields
         if ($sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, wdata, strb, resp, rdata) == 7)
         begin
            cur_name = name;
            run_case(op, addr, wdata, strb, resp, rdata);
         end
      end
      $fclose(fd);
   endtask

   initial begin
      int t;
      s_aw_valid = 1'b0;
      s_aw_addr = '0;
      s_w_valid = 1'b0;
      s_w_data = '0;
      s_w_strb = '0;
      s_b_ready = 1'b0;
      s_ar_valid = 1'b0;
      s_ar_addr = '0;
      s_r_ready = 1'b0;
      lfsr_q = LFSR_SEED;
      rand_en = 1'b0;
      aborted = 1'b0;
      pass_count = 0;
      fail_count = 0;
      round = 0;
      cur_name = "reset_state";
      test_err = 0;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!arst_n && t < TIMEOUT);
      if (!arst_n) report_timeout("reset was not released");
      @(negedge clk);
      check_eq("upstream valids", 64'd0, 64'({s_b_valid, s_r_valid}));
      check_eq("device valids", 64'd0, 64'({m_aw_valid, m_w_valid, m_b_ready,
                                           m_ar_valid, m_r_ready}));
      check_eq("upstream readies", 64'h7, 64'({s_aw_ready, s_w_ready, s_ar_ready}));
      finish_test();
      // second round adds random stalls on both sides
      round = 1;
      if (!aborted) run_cases();
      round = 2;
      rand_en = 1'b1;
      if (!aborted) run_cases();
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && !aborted) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- verif/io_cases.txt
# name op addr wdata strb resp rdata, all numbers hex
# resp 0 is okay and 3 is decode error, rdata only counts for reads
host_wr       write 40000010 1122334455667788 ff 0 0
host_rd       read  40000010 0 0 0 1122334455667788
uart_wr       write 40001010 0123456789abcdef ff 0 0
spi_wr        write 40002010 fedcba9876543210 ff 0 0
uart_rd       read  40001010 0 0 0 0123456789abcdef
spi_rd        read  40002010 0 0 0 fedcba9876543210
uart_top_wr   write 40001ff8 a5a5a5a55a5a5a5a ff 0 0
uart_top_rd   read  40001ff8 0 0 0 a5a5a5a55a5a5a5a
gap_wr        write 40003000 deadbeefdeadbeef ff 3 0
gap_rd        read  40003000 0 0 3 0
low_wr        write 3ffffff8 0badc0de0badc0de ff 3 0
low_rd        read  3ffffff8 0 0 3 0
strb_full_wr  write 40000020 aaaaaaaaaaaaaaaa ff 0 0
strb_low_wr   write 40000020 5555555555555555 0f 0 0
strb_low_rd   read  40000020 0 0 0 aaaaaaaa55555555
spi_high_wr   write 40002010 0000000000000000 f0 0 0
spi_high_rd   read  40002010 0 0 0 0000000076543210
uart_again_rd read  40001010 0 0 0 0123456789abcdef

//--- flist.f
common/lite_bus_pkg.sv
common/io_map_pkg.sv
common/lite_if.sv
io_crossbar/io_addr_decode.sv
io_crossbar/io_write_router.sv
io_crossbar/io_read_router.sv
src/io_subsys_top.sv
verif/tb_clock_gen.sv
verif/tb_io_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_subsys
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
